// ==== common/soc_defs.svh ====
// soc address map and sizes
`ifndef SOC_DEFS_SVH
`define SOC_DEFS_SVH

`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// clock and boot ram size
`define SYSTEM_CLK 32'd25_000_000
`define BRAM_WORDS 1024
`define BRAM_ADDR_W $clog2(`BRAM_WORDS)

// uart channels, write goes to tx and read comes from rx
`define NUM_UARTS 2
`define UART_TX_ADDR0 32'h1000_0000
`define UART_RX_ADDR0 32'h1000_0000
`define UART_LSR_ADDR0 32'h1000_0005
`define UART_TX_ADDR1 32'h1000_0100
`define UART_RX_ADDR1 32'h1000_0100
`define UART_LSR_ADDR1 32'h1000_0105

// system control
`define CPU_FREQ_REG_ADDR 32'h1100_0004
`define DIV_ADDR 32'h1100_0008
`define REBOOT_ADDR 32'h1110_0000
`define REBOOT_DATA 16'h7777

// io window, both ends inclusive
`define IO_BASE 32'h1000_0000
`define IO_LAST 32'h1200_0000

`endif

// ==== common/soc_pkg.sv ====
// soc bus and uart types
`include "soc_defs.svh"

package soc_pkg;

  // cpu bus
  typedef logic [`ADDR_WIDTH-1:0] bus_addr_t;
  typedef logic [`DATA_WIDTH-1:0] bus_data_t;
  // any strobe bit set means write
  typedef logic [`DATA_WIDTH/8-1:0] bus_strb_t;

  // uart
  typedef logic [7:0] uart_byte_t;
  typedef logic [15:0] uart_div_t;

  typedef struct packed {
    logic       rsvd7;
    logic       tx_empty;
    logic       thr_empty;
    logic [3:0] rsvd;
    logic       rx_ready;
  } lsr_t;

endpackage

// ==== common/io_bus_if.sv ====
// router to slave register port
`timescale 1ns/1ps

interface io_bus_if;
  import soc_pkg::*;

  // request, held steady by the router
  logic      sel;
  bus_addr_t addr;
  bus_strb_t wstrb;
  bus_data_t wdata;
  // reply, registered in the slave
  bus_data_t rdata;
  logic      ready;

  modport router (
    output sel, addr, wstrb, wdata,
    input  rdata, ready
  );

  modport slave (
    input  sel, addr, wstrb, wdata,
    output rdata, ready
  );

endinterface

// ==== uart/uart_tx.sv ====
// uart 8n1 transmitter
`timescale 1ns/1ps

module uart_tx (
  input  logic                clk,
  input  logic                resetn,
  input  logic                start_i,
  input  soc_pkg::uart_byte_t data_i,
  input  soc_pkg::uart_div_t  div_i,
  output logic                tx_o,
  output logic                busy_o
);
  import soc_pkg::*;

  uart_div_t  cnt;
  logic [3:0] bits_left;
  // stop bit sits above the data byte
  logic [8:0] shreg;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      tx_o      <= 1'b1;
      busy_o    <= 1'b0;
      cnt       <= '0;
      bits_left <= '0;
    end else if (!busy_o) begin
      // start bit goes out right away
      if (start_i) begin
        tx_o      <= 1'b0;
        busy_o    <= 1'b1;
        cnt       <= '0;
        bits_left <= 4'd9;
        shreg     <= {1'b1, data_i};
      end
    end else if (cnt == div_i - 1'b1) begin
      cnt <= '0;
      if (bits_left != 4'd0) begin
        tx_o      <= shreg[0];
        shreg     <= {1'b1, shreg[8:1]};
        bits_left <= bits_left - 1'b1;
      end else begin
        // end of stop bit
        busy_o <= 1'b0;
      end
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// ==== uart/uart_rx.sv ====
// uart 8n1 receiver
`timescale 1ns/1ps

module uart_rx (
  input  logic               clk,
  input  logic               resetn,
  input  logic               rx_i,
  input  soc_pkg::uart_div_t div_i,
  input  logic               pop_i,
  output soc_pkg::bus_data_t data_o,
  output logic               valid_o
);
  import soc_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_START,
    S_DATA,
    S_STOP
  } rx_state_t;

  rx_state_t  state;
  logic [1:0] sync_q;
  logic       rx_s;
  uart_div_t  cnt;
  logic [2:0] bit_idx;
  uart_byte_t shreg;
  uart_byte_t hold;

  assign rx_s   = sync_q[1];
  assign data_o = valid_o ? bus_data_t'(hold) : '1;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      sync_q  <= 2'b11;
      state   <= S_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      valid_o <= 1'b0;
    end else begin
      sync_q <= {sync_q[0], rx_i};
      if (pop_i) begin
        valid_o <= 1'b0;
      end
      case (state)
        S_IDLE: begin
          cnt <= '0;
          if (!rx_s) begin
            state <= S_START;
          end
        end
        // half a bit in to land mid start bit
        S_START: begin
          if (cnt == (div_i >> 1) - 1'b1) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_s ? S_IDLE : S_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        S_DATA: begin
          if (cnt == div_i - 1'b1) begin
            cnt     <= '0;
            shreg   <= {rx_s, shreg[7:1]};
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= S_STOP;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        S_STOP: begin
          if (cnt == div_i - 1'b1) begin
            cnt   <= '0;
            state <= S_IDLE;
            // new byte overwrites a full holding register
            if (rx_s) begin
              hold    <= shreg;
              valid_o <= 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

endmodule

// ==== uart/uart_channel.sv ====
// uart register slave
`timescale 1ns/1ps

module uart_channel (
  input  logic               clk,
  input  logic               resetn,
  io_bus_if.slave            bus,
  input  soc_pkg::uart_div_t div_i,
  output logic               tx_o,
  input  logic               rx_i
);
  import soc_pkg::*;

  logic      wr;
  logic      is_lsr;
  logic      tx_start;
  logic      rx_pop;
  logic      tx_busy;
  logic      rx_valid;
  bus_data_t rx_data;
  lsr_t      lsr;
  logic      ready_q;
  bus_data_t rdata_q;

  // bit 2 splits lsr from the tx/rx data register
  assign wr       = |bus.wstrb;
  assign is_lsr   = bus.addr[2];
  assign tx_start = bus.sel && wr && !is_lsr;
  assign rx_pop   = bus.sel && !wr && !is_lsr;

  always_comb begin
    lsr           = '0;
    lsr.rx_ready  = rx_valid;
    lsr.thr_empty = !tx_busy;
    lsr.tx_empty  = !tx_busy;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= bus.sel;
    end
  end

  // rx byte captured before the pop clears it
  always_ff @(posedge clk) begin
    if (bus.sel) begin
      if (wr) begin
        rdata_q <= '0;
      end else if (is_lsr) begin
        rdata_q <= {16'b0, lsr, 8'b0};
      end else begin
        rdata_q <= rx_data;
      end
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;

  uart_tx u_uart_tx (
    .clk    (clk),
    .resetn (resetn),
    .start_i(tx_start),
    .data_i (uart_byte_t'(bus.wdata[7:0])),
    .div_i  (div_i),
    .tx_o   (tx_o),
    .busy_o (tx_busy)
  );

  uart_rx u_uart_rx (
    .clk    (clk),
    .resetn (resetn),
    .rx_i   (rx_i),
    .div_i  (div_i),
    .pop_i  (rx_pop),
    .data_o (rx_data),
    .valid_o(rx_valid)
  );

endmodule

// ==== hdl/boot_ram.sv ====
// boot ram
`timescale 1ns/1ps
`include "soc_defs.svh"

module boot_ram (
  input  logic                      clk,
  input  logic [`BRAM_ADDR_W-1:0]   addr_i,
  input  logic [`DATA_WIDTH-1:0]    wdata_i,
  input  logic [`DATA_WIDTH/8-1:0]  wmask_i,
  output logic [`DATA_WIDTH-1:0]    rdata_o
);

  logic [`DATA_WIDTH-1:0] mem [`BRAM_WORDS];

  // byte lanes written under mask
  always_ff @(posedge clk) begin
    for (int b = 0; b < `DATA_WIDTH / 8; b++) begin
      if (wmask_i[b]) begin
        mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
      end
    end
  end

  // read returns the old word on a write cycle
  always_ff @(posedge clk) begin
    rdata_o <= mem[addr_i];
  end

endmodule

// ==== hdl/syscon.sv ====
// system control registers
`timescale 1ns/1ps
`include "soc_defs.svh"

module syscon (
  input  logic               clk,
  input  logic               resetn,
  io_bus_if.slave            bus,
  output soc_pkg::bus_data_t div_o,
  output logic               reboot_o
);
  import soc_pkg::*;

  // register select from address bits 3:2
  localparam logic [1:0] REG_REBOOT = 2'b00;
  localparam logic [1:0] REG_FREQ   = 2'b01;
  localparam logic [1:0] REG_DIV    = 2'b10;

  logic      wr;
  logic      ready_q;
  bus_data_t rdata_q;

  assign wr = |bus.wstrb;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q  <= 1'b0;
      div_o    <= '0;
      reboot_o <= 1'b0;
    end else begin
      ready_q  <= bus.sel;
      // key write gives a single pulse since sel lasts one cycle
      reboot_o <= bus.sel && wr && (bus.addr[3:2] == REG_REBOOT) &&
                  (bus.wdata[15:0] == `REBOOT_DATA);
      if (bus.sel && (&bus.wstrb) && (bus.addr[3:2] == REG_DIV)) begin
        div_o <= bus.wdata;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.sel) begin
      case (bus.addr[3:2])
        REG_FREQ: rdata_q <= `SYSTEM_CLK;
        REG_DIV:  rdata_q <= div_o;
        default:  rdata_q <= '0;
      endcase
    end
  end

  assign bus.ready = ready_q;
  assign bus.rdata = rdata_q;

endmodule

// ==== hdl/mem_router.sv ====
// cpu bus address router
`timescale 1ns/1ps
`include "soc_defs.svh"

module mem_router #(
  parameter int NUM_UARTS = `NUM_UARTS
) (
  input  logic                    clk,
  input  logic                    resetn,
  input  logic                    mem_valid_i,
  input  soc_pkg::bus_addr_t      mem_addr_i,
  input  soc_pkg::bus_strb_t      mem_wstrb_i,
  input  soc_pkg::bus_data_t      mem_wdata_i,
  input  logic                    is_instr_i,
  output logic                    mem_ready_o,
  output soc_pkg::bus_data_t      mem_rdata_o,
  output logic                    access_fault_o,
  output logic [`BRAM_ADDR_W-1:0] ram_addr_o,
  output soc_pkg::bus_data_t      ram_wdata_o,
  output soc_pkg::bus_strb_t      ram_wmask_o,
  input  soc_pkg::bus_data_t      ram_rdata_i,
  io_bus_if.router                sys_bus,
  io_bus_if.router                uart_bus [NUM_UARTS]
);
  import soc_pkg::*;

  localparam bus_addr_t RAM_END    = bus_addr_t'(`BRAM_WORDS * 4);
  localparam bus_addr_t TX_STRIDE  = `UART_TX_ADDR1 - `UART_TX_ADDR0;
  localparam bus_addr_t RX_STRIDE  = `UART_RX_ADDR1 - `UART_RX_ADDR0;
  localparam bus_addr_t LSR_STRIDE = `UART_LSR_ADDR1 - `UART_LSR_ADDR0;

  logic                 is_ram;
  logic                 is_io;
  logic                 is_reboot;
  logic                 is_sys;
  logic                 is_data;
  logic [NUM_UARTS-1:0] is_uart;
  logic [NUM_UARTS-1:0] uart_ready;
  bus_data_t            uart_rdata [NUM_UARTS];
  logic                 ram_valid;
  logic                 fault_valid;
  logic                 unm_valid;
  logic                 ram_ready_q;
  logic                 fault_q;
  logic                 unm_q;

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////
  assign is_ram    = mem_addr_i < RAM_END;
  assign is_io     = (mem_addr_i >= `IO_BASE) && (mem_addr_i <= `IO_LAST);
  assign is_reboot = mem_addr_i == `REBOOT_ADDR;
  assign is_sys    = (mem_addr_i == `CPU_FREQ_REG_ADDR) || (mem_addr_i == `DIV_ADDR) || is_reboot;
  assign is_data   = mem_valid_i && !is_instr_i;

  // fetches only from ram, data also from io and the reboot key
  assign fault_valid = mem_valid_i && !fault_q &&
                       (is_instr_i ? !is_ram : !(is_ram || is_io || is_reboot));
  assign unm_valid   = is_data && !unm_q && is_io && !is_sys && !(|is_uart);

  // ram port, writes masked off unless this is a fresh ram request
  assign ram_valid   = mem_valid_i && is_ram && !ram_ready_q;
  assign ram_addr_o  = mem_addr_i[`BRAM_ADDR_W+1:2];
  assign ram_wdata_o = mem_wdata_i;
  assign ram_wmask_o = mem_wstrb_i & {$bits(bus_strb_t){ram_valid}};

  assign sys_bus.sel   = is_data && is_sys && !sys_bus.ready;
  assign sys_bus.addr  = mem_addr_i;
  assign sys_bus.wstrb = mem_wstrb_i;
  assign sys_bus.wdata = mem_wdata_i;

  for (genvar i = 0; i < NUM_UARTS; i++) begin : g_uart
    localparam bus_addr_t TX_ADDR  = `UART_TX_ADDR0 + bus_addr_t'(i) * TX_STRIDE;
    localparam bus_addr_t RX_ADDR  = `UART_RX_ADDR0 + bus_addr_t'(i) * RX_STRIDE;
    localparam bus_addr_t LSR_ADDR = `UART_LSR_ADDR0 + bus_addr_t'(i) * LSR_STRIDE;

    assign is_uart[i] = (mem_addr_i == TX_ADDR) || (mem_addr_i == RX_ADDR) ||
                        (mem_addr_i == LSR_ADDR);

    assign uart_bus[i].sel   = is_data && is_uart[i] && !uart_bus[i].ready;
    assign uart_bus[i].addr  = mem_addr_i;
    assign uart_bus[i].wstrb = mem_wstrb_i;
    assign uart_bus[i].wdata = mem_wdata_i;

    assign uart_ready[i] = uart_bus[i].ready;
    assign uart_rdata[i] = uart_bus[i].rdata;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ram_ready_q <= 1'b0;
      fault_q     <= 1'b0;
      unm_q       <= 1'b0;
    end else begin
      ram_ready_q <= ram_valid;
      fault_q     <= fault_valid;
      unm_q       <= unm_valid;
    end
  end

  ////////////////////////////////////////
  // reply merge
  ////////////////////////////////////////
  assign mem_ready_o    = ram_ready_q || (|uart_ready) || sys_bus.ready || unm_q || fault_q;
  assign access_fault_o = fault_q;

  // faults and unmatched io fall through to zero
  always_comb begin
    mem_rdata_o = '0;
    if (ram_ready_q) begin
      mem_rdata_o = ram_rdata_i;
    end else if (|uart_ready) begin
      // walk down so the lowest index wins
      for (int k = NUM_UARTS - 1; k >= 0; k--) begin
        if (uart_ready[k]) begin
          mem_rdata_o = uart_rdata[k];
        end
      end
    end else if (sys_bus.ready) begin
      mem_rdata_o = sys_bus.rdata;
    end
  end

endmodule

// ==== hdl/soc_io.sv ====
// soc peripheral fabric top
`timescale 1ns/1ps
`include "soc_defs.svh"

module soc_io #(
  parameter int NUM_UARTS = `NUM_UARTS
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  mem_valid_i,
  input  soc_pkg::bus_addr_t    mem_addr_i,
  input  soc_pkg::bus_strb_t    mem_wstrb_i,
  input  soc_pkg::bus_data_t    mem_wdata_i,
  input  logic                  is_instr_i,
  output logic                  mem_ready_o,
  output soc_pkg::bus_data_t    mem_rdata_o,
  output logic                  access_fault_o,
  input  logic [NUM_UARTS-1:0]  uart_rx_i,
  output logic [NUM_UARTS-1:0]  uart_tx_o,
  output logic                  reboot_o
);
  import soc_pkg::*;

  logic [`BRAM_ADDR_W-1:0] ram_addr;
  bus_data_t               ram_wdata;
  bus_data_t               ram_rdata;
  bus_strb_t               ram_wmask;
  bus_data_t               div;

  io_bus_if sys_bus ();
  io_bus_if uart_bus [NUM_UARTS] ();

  mem_router #(
    .NUM_UARTS(NUM_UARTS)
  ) u_mem_router (
    .clk           (clk),
    .resetn        (resetn),
    .mem_valid_i   (mem_valid_i),
    .mem_addr_i    (mem_addr_i),
    .mem_wstrb_i   (mem_wstrb_i),
    .mem_wdata_i   (mem_wdata_i),
    .is_instr_i    (is_instr_i),
    .mem_ready_o   (mem_ready_o),
    .mem_rdata_o   (mem_rdata_o),
    .access_fault_o(access_fault_o),
    .ram_addr_o    (ram_addr),
    .ram_wdata_o   (ram_wdata),
    .ram_wmask_o   (ram_wmask),
    .ram_rdata_i   (ram_rdata),
    .sys_bus       (sys_bus),
    .uart_bus      (uart_bus)
  );

  boot_ram u_boot_ram (
    .clk    (clk),
    .addr_i (ram_addr),
    .wdata_i(ram_wdata),
    .wmask_i(ram_wmask),
    .rdata_o(ram_rdata)
  );

  syscon u_syscon (
    .clk     (clk),
    .resetn  (resetn),
    .bus     (sys_bus),
    .div_o   (div),
    .reboot_o(reboot_o)
  );

  // low half of the divider is the uart bit period
  for (genvar i = 0; i < NUM_UARTS; i++) begin : g_uart
    uart_channel u_uart_channel (
      .clk   (clk),
      .resetn(resetn),
      .bus   (uart_bus[i]),
      .div_i (uart_div_t'(div[15:0])),
      .tx_o  (uart_tx_o[i]),
      .rx_i  (uart_rx_i[i])
    );
  end

endmodule

// ==== tb/soc_io_assertions.sv ====
// bus protocol assertions
`timescale 1ns/1ps

module soc_io_assertions (
  input logic        clk,
  input logic        resetn,
  input logic        mem_valid_i,
  input logic        mem_ready_o,
  input logic [31:0] mem_rdata_o,
  input logic        access_fault_o,
  input logic        reboot_o
);

  // ready only answers a request seen on the previous edge
  a_ready_after_valid: assert property (
    @(posedge clk) disable iff (!resetn) mem_ready_o |-> $past(mem_valid_i)
  ) else $error("mem_ready_o high without a request in the previous cycle");

  // a fault is a ready with zero data
  a_fault_with_ready: assert property (
    @(posedge clk) disable iff (!resetn)
      access_fault_o |-> mem_ready_o && (mem_rdata_o == 32'h0)
  ) else $error("access_fault_o without mem_ready_o or with nonzero read data");

  // reboot is a single cycle pulse
  a_reboot_pulse: assert property (
    @(posedge clk) disable iff (!resetn) $rose(reboot_o) |=> !reboot_o
  ) else $error("reboot_o held for more than one cycle");

endmodule

// ==== tb/tb_soc_io.sv ====
// soc_io testbench
`timescale 1ns/1ps
`include "soc_defs.svh"

module tb_soc_io;

  localparam int          UART_IDX_W  = $clog2(`NUM_UARTS);
  localparam int          BUS_TIMEOUT = 16;
  localparam int          POLL_LIMIT  = 40;
  localparam int          BIT_CYCLES  = 8;
  localparam logic [31:0] RAM_BYTES   = 32'(`BRAM_WORDS * 4);

  logic                  clk;
  logic                  resetn;
  logic                  mem_valid_i;
  logic [31:0]           mem_addr_i;
  logic [3:0]            mem_wstrb_i;
  logic [31:0]           mem_wdata_i;
  logic                  is_instr_i;
  logic                  mem_ready_o;
  logic [31:0]           mem_rdata_o;
  logic                  access_fault_o;
  logic [`NUM_UARTS-1:0] uart_rx_i;
  logic [`NUM_UARTS-1:0] uart_tx_o;
  logic                  reboot_o;

  // reference model state
  logic [31:0] shadow_mem [`BRAM_WORDS];
  logic [31:0] shadow_div;
  logic [31:0] lfsr;
  logic [31:0] ram_addrs [$];

  // expectation for the reply in flight
  logic [31:0] exp_rdata;
  logic        exp_fault;
  logic        exp_has_data;

  soc_io u_soc_io (
    .clk           (clk),
    .resetn        (resetn),
    .mem_valid_i   (mem_valid_i),
    .mem_addr_i    (mem_addr_i),
    .mem_wstrb_i   (mem_wstrb_i),
    .mem_wdata_i   (mem_wdata_i),
    .is_instr_i    (is_instr_i),
    .mem_ready_o   (mem_ready_o),
    .mem_rdata_o   (mem_rdata_o),
    .access_fault_o(access_fault_o),
    .uart_rx_i     (uart_rx_i),
    .uart_tx_o     (uart_tx_o),
    .reboot_o      (reboot_o)
  );

  bind soc_io soc_io_assertions u_soc_io_assertions (
    .clk           (clk),
    .resetn        (resetn),
    .mem_valid_i   (mem_valid_i),
    .mem_ready_o   (mem_ready_o),
    .mem_rdata_o   (mem_rdata_o),
    .access_fault_o(access_fault_o),
    .reboot_o      (reboot_o)
  );

  always #20 clk = ~clk;

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    // fibonacci taps 32 22 2 1
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic logic expected_fault(input logic [31:0] addr, input logic instr);
    logic in_ram;
    logic in_io;
    in_ram = addr < RAM_BYTES;
    in_io  = (addr >= `IO_BASE) && (addr <= `IO_LAST);
    if (instr) begin
      return !in_ram;
    end
    return !(in_ram || in_io || (addr == `REBOOT_ADDR));
  endfunction

  // faults, reboot and unmatched io all read as zero
  function automatic logic [31:0] expected_read(input logic [31:0] addr, input logic instr);
    if (addr < RAM_BYTES) begin
      return shadow_mem[addr[`BRAM_ADDR_W+1:2]];
    end else if (instr) begin
      return '0;
    end else if (addr == `DIV_ADDR) begin
      return shadow_div;
    end else if (addr == `CPU_FREQ_REG_ADDR) begin
      return `SYSTEM_CLK;
    end
    return '0;
  endfunction

  function automatic logic [31:0] lsr_word(input logic rx_ready, input logic tx_idle);
    logic [7:0] lsr;
    lsr = {1'b0, tx_idle, tx_idle, 4'b0, rx_ready};
    return {16'b0, lsr, 8'b0};
  endfunction

  function automatic logic [31:0] uart_data_addr(input int u);
    return `UART_TX_ADDR0 + 32'(u) * (`UART_TX_ADDR1 - `UART_TX_ADDR0);
  endfunction

  function automatic logic [31:0] uart_lsr_addr(input int u);
    return `UART_LSR_ADDR0 + 32'(u) * (`UART_LSR_ADDR1 - `UART_LSR_ADDR0);
  endfunction

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////
  task automatic fail_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  always @(negedge clk) begin : compare_replies
    if (resetn && mem_ready_o) begin
      check("access_fault_o", 32'(access_fault_o), 32'(exp_fault));
      if (exp_has_data) begin
        check("mem_rdata_o", mem_rdata_o, exp_rdata);
      end
    end
  end

  ////////////////////////////////////////
  // bus and serial tasks
  ////////////////////////////////////////
  task automatic bus_transfer(input logic [31:0] addr, input logic [3:0] strb,
                              input logic [31:0] wdata, input logic instr,
                              input logic has_data, input logic [31:0] exp,
                              output logic [31:0] rdata);
    int waited;
    @(negedge clk);
    exp_fault    = expected_fault(addr, instr);
    exp_has_data = has_data;
    exp_rdata    = exp;
    mem_valid_i  = 1'b1;
    mem_addr_i   = addr;
    mem_wstrb_i  = strb;
    mem_wdata_i  = wdata;
    is_instr_i   = instr;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (!mem_ready_o && waited < BUS_TIMEOUT);
    if (!mem_ready_o) begin
      $display("no ready from the bus for address %h", addr);
      fail_run();
    end
    check("ready latency", 32'(waited), 32'd1);
    rdata       = mem_rdata_o;
    mem_valid_i = 1'b0;
    mem_wstrb_i = '0;
    is_instr_i  = 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] strb,
                           input logic [31:0] wdata);
    logic [31:0] unused_rdata;
    if (addr < RAM_BYTES) begin
      for (int b = 0; b < 4; b++) begin
        if (strb[b]) begin
          shadow_mem[addr[`BRAM_ADDR_W+1:2]][8*b +: 8] = wdata[8*b +: 8];
        end
      end
    end
    if (addr == `DIV_ADDR && (&strb)) begin
      shadow_div = wdata;
    end
    bus_transfer(addr, strb, wdata, 1'b0, 1'b0, '0, unused_rdata);
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic instr,
                          input logic [31:0] exp);
    logic [31:0] unused_rdata;
    bus_transfer(addr, 4'h0, '0, instr, 1'b1, exp, unused_rdata);
  endtask

  task automatic bus_peek(input logic [31:0] addr, output logic [31:0] rdata);
    bus_transfer(addr, 4'h0, '0, 1'b0, 1'b0, '0, rdata);
  endtask

  // entered in the cycle the start bit began
  task automatic sample_tx_frame(input int u, output logic [7:0] data);
    repeat (BIT_CYCLES / 2) @(negedge clk);
    check("uart_tx_o start bit", 32'(uart_tx_o[UART_IDX_W'(u)]), 32'h0);
    for (int j = 0; j < 8; j++) begin
      repeat (BIT_CYCLES) @(negedge clk);
      data[j] = uart_tx_o[UART_IDX_W'(u)];
    end
    repeat (BIT_CYCLES) @(negedge clk);
    check("uart_tx_o stop bit", 32'(uart_tx_o[UART_IDX_W'(u)]), 32'h1);
  endtask

  task automatic send_rx_frame(input int u, input logic [7:0] data);
    @(negedge clk);
    uart_rx_i[UART_IDX_W'(u)] = 1'b0;
    repeat (BIT_CYCLES) @(negedge clk);
    for (int j = 0; j < 8; j++) begin
      uart_rx_i[UART_IDX_W'(u)] = data[j];
      repeat (BIT_CYCLES) @(negedge clk);
    end
    uart_rx_i[UART_IDX_W'(u)] = 1'b1;
    repeat (BIT_CYCLES) @(negedge clk);
  endtask

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////
  initial begin : stimulus
    logic [31:0] addr;
    logic [31:0] rdata;
    logic [3:0]  strb;
    logic [7:0]  tx_byte;
    logic [7:0]  got_byte;
    int          waited;
    clk          = 1'b0;
    resetn       = 1'b0;
    mem_valid_i  = 1'b0;
    mem_addr_i   = '0;
    mem_wstrb_i  = '0;
    mem_wdata_i  = '0;
    is_instr_i   = 1'b0;
    uart_rx_i    = '1;
    lfsr         = 32'h0d747a54;
    shadow_div   = '0;
    exp_rdata    = '0;
    exp_fault    = 1'b0;
    exp_has_data = 1'b0;
    repeat (5) @(negedge clk);
    resetn = 1'b1;
    check("mem_ready_o", 32'(mem_ready_o), 32'h0);
    check("access_fault_o", 32'(access_fault_o), 32'h0);
    check("reboot_o", 32'(reboot_o), 32'h0);
    check("uart_tx_o", 32'(uart_tx_o), 32'({`NUM_UARTS{1'b1}}));

    // full words first so partial writes merge into known data
    for (int i = 0; i < 8; i++) begin
      addr = {20'b0, 10'(take_bits(10)), 2'b00};
      ram_addrs.push_back(addr);
      bus_write(addr, 4'hf, take_bits(32));
    end
    foreach (ram_addrs[i]) begin
      strb = 4'(take_bits(4));
      if (strb == 4'h0) begin
        strb = 4'h5;
      end
      bus_write(ram_addrs[i], strb, take_bits(32));
    end
    foreach (ram_addrs[i]) begin
      bus_read(ram_addrs[i], 1'b0, expected_read(ram_addrs[i], 1'b0));
    end
    bus_read(ram_addrs[0], 1'b1, expected_read(ram_addrs[0], 1'b1));

    // system control
    bus_write(`DIV_ADDR, 4'hf, 32'(BIT_CYCLES));
    bus_read(`DIV_ADDR, 1'b0, expected_read(`DIV_ADDR, 1'b0));
    bus_read(`CPU_FREQ_REG_ADDR, 1'b0, expected_read(`CPU_FREQ_REG_ADDR, 1'b0));
    bus_write(`REBOOT_ADDR, 4'hf, {16'h0, `REBOOT_DATA});
    check("reboot_o", 32'(reboot_o), 32'h1);
    @(negedge clk);
    check("reboot_o", 32'(reboot_o), 32'h0);
    bus_write(`REBOOT_ADDR, 4'hf, {16'h0, `REBOOT_DATA ^ 16'h0001});
    check("reboot_o", 32'(reboot_o), 32'h0);
    @(negedge clk);
    check("reboot_o", 32'(reboot_o), 32'h0);

    // uart transmit with an lsr read while the frame is on the line
    for (int u = 0; u < `NUM_UARTS; u++) begin
      tx_byte = 8'(take_bits(8));
      bus_write(uart_data_addr(u), 4'h1, {24'b0, tx_byte});
      fork
        sample_tx_frame(u, got_byte);
        bus_read(uart_lsr_addr(u), 1'b0, lsr_word(1'b0, 1'b0));
      join
      check("uart_tx_o byte", {24'b0, got_byte}, {24'b0, tx_byte});
      // rest of the stop bit
      repeat (BIT_CYCLES / 2) @(negedge clk);
      bus_read(uart_lsr_addr(u), 1'b0, lsr_word(1'b0, 1'b1));
    end

    // uart receive
    for (int u = 0; u < `NUM_UARTS; u++) begin
      tx_byte = 8'(take_bits(8));
      send_rx_frame(u, tx_byte);
      rdata  = '0;
      waited = 0;
      while (!rdata[8] && waited < POLL_LIMIT) begin
        bus_peek(uart_lsr_addr(u), rdata);
        waited++;
      end
      if (!rdata[8]) begin
        $display("uart %0d never flagged the received byte in its line status", u);
        fail_run();
      end
      check("uart lsr", rdata, lsr_word(1'b1, 1'b1));
      bus_read(uart_data_addr(u), 1'b0, {24'b0, tx_byte});
      bus_read(uart_data_addr(u), 1'b0, 32'hffff_ffff);
    end

    // faults and unmatched io
    bus_read(32'h2000_0000, 1'b0, expected_read(32'h2000_0000, 1'b0));
    bus_read(`IO_BASE, 1'b1, expected_read(`IO_BASE, 1'b1));
    bus_read(32'h1000_0800, 1'b0, expected_read(32'h1000_0800, 1'b0));

    repeat (2) @(negedge clk);
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+common
common/soc_pkg.sv
common/io_bus_if.sv
uart/uart_tx.sv
uart/uart_rx.sv
uart/uart_channel.sv
hdl/boot_ram.sv
hdl/syscon.sv
hdl/mem_router.sv
hdl/soc_io.sv
tb/soc_io_assertions.sv
tb/tb_soc_io.sv

// ==== run.sh ====
#!/bin/sh
# build and run the soc_io testbench with verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_soc_io -f flist.f -o tb_soc_io
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_soc_io > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0
